// ==== sources.f ====
source/rv_core_pkg.sv
source/fetch_unit.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/retire_stage.sv
source/rv_core.sv
tb/tb_clock_gen.sv
tb/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f sources.f \
    -o sim_rv_core || exit 1
./obj_dir/sim_rv_core > sim.log 2>&1
cat sim.log
grep -q '^STATUS: PASS$' sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// ==== tb/tb_rv_core.sv ====
// testbench for rv_core with memory models, test table, program builder, checks and watchdog
`timescale 1ns/1ps
module tb_rv_core;

    localparam logic [31:0] RESET_PC     = 32'h0;
    localparam logic [31:0] RESULT_ADDR  = 32'h100;
    localparam logic [31:0] SKIP_ADDR    = 32'h104;
    localparam int          RESET_CYCLES = 4;
    localparam int          CYCLES_EACH  = 200;
    localparam logic [6:0]  OPC_IMM      = 7'b0010011;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic        skip_seen;
    } test_data_t;

    logic        clk;
    logic        init_reset;
    logic        test_reset;
    logic        reset_dut;
    logic        stall_i;
    logic [31:0] instruction_i;
    logic [31:0] mem_data_i;
    logic [31:0] instruction_address_o;
    logic        mem_operation_enable_o;
    logic [3:0]  mem_write_enable_o;
    logic [31:0] mem_address_o;
    logic [31:0] mem_data_o;
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    int          store_count = 0;
    int          skip_count = 0;
    logic [31:0] last_store = '0;
    logic        table_ready = 1'b0;
    string       names [$];
    string       ops [$];
    test_data_t  data [$];

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk    (clk),
        .reset_o(init_reset)
    );

    assign reset_dut = init_reset | test_reset;

    rv_core #(.RESET_PC(RESET_PC)) u_rv_core (
        .clk                   (clk),
        .reset                 (reset_dut),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .mem_data_i            (mem_data_i),
        .instruction_address_o (instruction_address_o),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o    (mem_write_enable_o),
        .mem_address_o         (mem_address_o),
        .mem_data_o            (mem_data_o)
    );

    // instruction memory answers every cycle
    assign instruction_i = imem[instruction_address_o[9:2]];
    // data memory answers in the same cycle, only on an enabled read
    assign mem_data_i    = (mem_operation_enable_o && mem_write_enable_o == 4'b0000) ?
                           dmem[mem_address_o[9:2]] : '0;

    // data memory, store monitor and stall rule
    always @(posedge clk) begin
        if (reset_dut) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h11};
            end
        end else if (stall_i && mem_operation_enable_o) begin
            $display("memory operation was issued while stall was high");
            $display("STATUS: FAIL");
            $fatal(1);
        end else if (mem_operation_enable_o && mem_write_enable_o == 4'b1111) begin
            dmem[mem_address_o[9:2]] <= mem_data_o;
            if (mem_address_o == RESULT_ADDR) begin
                store_count <= store_count + 1;
                last_store  <= mem_data_o;
            end
            if (mem_address_o == SKIP_ADDR) begin
                skip_count <= skip_count + 1;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (CYCLES_EACH * names.size() + 20) @(posedge clk);
        $display("no store arrived in time, the run timed out");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected %08h actual %08h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic add_test(input string name, input string op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] expected,
                            input logic skip_seen);
        names.push_back(name);
        ops.push_back(op);
        data.push_back('{a, b, expected, skip_seen});
    endtask

    // RV32I instruction formats
    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm,
                                          input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // operation under test with its result in x3
    // branch and jump targets land on the result store
    function automatic logic [31:0] main_instr(input string op, input logic [31:0] b);
        case (op)
            "add":   return enc_r(7'h00, 3'b000);
            "sub":   return enc_r(7'h20, 3'b000);
            "slt":   return enc_r(7'h00, 3'b010);
            "sltu":  return enc_r(7'h00, 3'b011);
            "xor":   return enc_r(7'h00, 3'b100);
            "or":    return enc_r(7'h00, 3'b110);
            "and":   return enc_r(7'h00, 3'b111);
            "sll":   return enc_r(7'h00, 3'b001);
            "srl":   return enc_r(7'h00, 3'b101);
            "sra":   return enc_r(7'h20, 3'b101);
            "addi":  return enc_i(3'b000, 5'd3, 5'd1, b[11:0], OPC_IMM);
            "slti":  return enc_i(3'b010, 5'd3, 5'd1, b[11:0], OPC_IMM);
            "sltiu": return enc_i(3'b011, 5'd3, 5'd1, b[11:0], OPC_IMM);
            "xori":  return enc_i(3'b100, 5'd3, 5'd1, b[11:0], OPC_IMM);
            "ori":   return enc_i(3'b110, 5'd3, 5'd1, b[11:0], OPC_IMM);
            "andi":  return enc_i(3'b111, 5'd3, 5'd1, b[11:0], OPC_IMM);
            "slli":  return enc_i(3'b001, 5'd3, 5'd1, {7'h00, b[4:0]}, OPC_IMM);
            "srli":  return enc_i(3'b101, 5'd3, 5'd1, {7'h00, b[4:0]}, OPC_IMM);
            "srai":  return enc_i(3'b101, 5'd3, 5'd1, {7'h20, b[4:0]}, OPC_IMM);
            "lui":   return {b[31:12], 5'd3, 7'b0110111};
            "auipc": return {b[31:12], 5'd3, 7'b0010111};
            "beq":   return enc_b(3'b000, 13'd8);
            "bne":   return enc_b(3'b001, 13'd8);
            "blt":   return enc_b(3'b100, 13'd8);
            "bge":   return enc_b(3'b101, 13'd8);
            "bltu":  return enc_b(3'b110, 13'd8);
            "bgeu":  return enc_b(3'b111, 13'd8);
            "jal":   return enc_j(5'd3, 21'd8);
            "jalr":  return enc_i(3'b000, 5'd3, 5'd1, 12'd0, 7'b1100111);
            default: return enc_i(3'b010, 5'd3, 5'd1, 12'd0, 7'b0000011);
        endcase
    endfunction

    task automatic build_program(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] a_hi;
        logic [31:0] b_hi;
        a    = data[idx].a;
        b    = data[idx].b;
        a_hi = a + 32'h800;
        b_hi = b + 32'h800;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        imem[0] = {a_hi[31:12], 5'd1, 7'b0110111};
        imem[1] = enc_i(3'b000, 5'd1, 5'd1, a[11:0], OPC_IMM);
        imem[2] = {b_hi[31:12], 5'd2, 7'b0110111};
        imem[3] = enc_i(3'b000, 5'd2, 5'd2, b[11:0], OPC_IMM);
        imem[4] = main_instr(ops[idx], b);
        case (ops[idx])
            "beq", "bne", "blt", "bge", "bltu", "bgeu", "jal", "jalr":
                imem[5] = enc_s(SKIP_ADDR[11:0], 5'd0);
            "lw":    imem[5] = enc_i(3'b000, 5'd3, 5'd3, 12'd1, OPC_IMM);
            default: imem[5] = enc_i(3'b000, 5'd0, 5'd0, 12'd0, OPC_IMM);
        endcase
        imem[6] = enc_s(RESULT_ADDR[11:0], 5'd3);
        imem[7] = enc_j(5'd0, 21'd0);
    endtask

    initial begin
        int stores_before;
        int skips_before;
        stall_i    = 1'b0;
        test_reset = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        void'($urandom(32'ha9737e02));
        add_test("add", "add", 32'h12345678, 32'h0f0f0f0f, 32'h21436587, 1'b0);
        add_test("sub", "sub", 32'd5, 32'd7, 32'hfffffffe, 1'b0);
        add_test("slt", "slt", 32'hffffffff, 32'd1, 32'd1, 1'b0);
        add_test("sltu", "sltu", 32'hffffffff, 32'd1, 32'd0, 1'b0);
        add_test("xor", "xor", 32'hff00ff00, 32'h0ff00ff0, 32'hf0f0f0f0, 1'b0);
        add_test("or", "or", 32'hff00ff00, 32'h0ff00ff0, 32'hfff0fff0, 1'b0);
        add_test("and", "and", 32'hff00ff00, 32'h0ff00ff0, 32'h0f000f00, 1'b0);
        add_test("sll", "sll", 32'h80000001, 32'd4, 32'h00000010, 1'b0);
        add_test("srl", "srl", 32'h80000000, 32'd31, 32'd1, 1'b0);
        add_test("sra", "sra", 32'h80000000, 32'd4, 32'hf8000000, 1'b0);
        add_test("addi", "addi", 32'd100, 32'hffffffff, 32'd99, 1'b0);
        add_test("slti", "slti", 32'hfffffffb, 32'd3, 32'd1, 1'b0);
        add_test("sltiu", "sltiu", 32'd2, 32'h00000fff, 32'd1, 1'b0);
        add_test("xori", "xori", 32'h0000ffff, 32'h00000800, 32'hffff07ff, 1'b0);
        add_test("ori", "ori", 32'h00000100, 32'h000000f0, 32'h000001f0, 1'b0);
        add_test("andi", "andi", 32'h12345678, 32'h000000ff, 32'h00000078, 1'b0);
        add_test("slli", "slli", 32'd3, 32'd30, 32'hc0000000, 1'b0);
        add_test("srli", "srli", 32'hf0000000, 32'd28, 32'h0000000f, 1'b0);
        add_test("srai", "srai", 32'hf0000000, 32'd28, 32'hffffffff, 1'b0);
        add_test("lui", "lui", 32'd0, 32'habcde000, 32'habcde000, 1'b0);
        add_test("auipc", "auipc", 32'd0, 32'h00001000, 32'h00001010, 1'b0);
        add_test("beq_taken", "beq", 32'd7, 32'd7, 32'd0, 1'b0);
        add_test("beq_not_taken", "beq", 32'd7, 32'd8, 32'd0, 1'b1);
        add_test("bne_taken", "bne", 32'd7, 32'd8, 32'd0, 1'b0);
        add_test("blt_taken", "blt", 32'hffffffff, 32'd1, 32'd0, 1'b0);
        add_test("bge_not_taken", "bge", 32'hffffffff, 32'd1, 32'd0, 1'b1);
        add_test("bltu_not_taken", "bltu", 32'hffffffff, 32'd1, 32'd0, 1'b1);
        add_test("bgeu_taken", "bgeu", 32'hffffffff, 32'd1, 32'd0, 1'b0);
        add_test("jal_link", "jal", 32'd0, 32'd0, 32'd20, 1'b0);
        add_test("jalr_link", "jalr", 32'd24, 32'd0, 32'd20, 1'b0);
        // preloaded word at 0x80 plus one
        add_test("lw_plus_one", "lw", 32'h00000080, 32'd0, 32'h20df7a32, 1'b0);
        table_ready = 1'b1;

        while (init_reset) @(posedge clk);
        for (int idx = 0; idx < names.size(); idx++) begin
            @(posedge clk);
            #1 test_reset = 1'b1;
            stall_i = 1'b0;
            build_program(idx);
            repeat (RESET_CYCLES) @(posedge clk);
            #1 test_reset = 1'b0;
            check_value({names[idx], " reset pc"}, RESET_PC, instruction_address_o);
            check_value({names[idx], " reset mem enable"}, 32'd0,
                        {31'd0, mem_operation_enable_o});
            stores_before = store_count;
            skips_before  = skip_count;
            while (store_count == stores_before) begin
                @(posedge clk);
                #1 stall_i = ($urandom % 4) == 0;
            end
            stall_i = 1'b0;
            check_value(names[idx], data[idx].expected, last_store);
            check_value({names[idx], " skipped store"}, {31'd0, data[idx].skip_seen},
                        {31'd0, skip_count != skips_before});
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
// clock and power-on reset generator for the core testbench
`timescale 1ns/1ps
module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset_o
);
    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_o = 1'b0;
    end

endmodule

// ==== source/rv_core.sv ====
// top level of the in-order RV32I core connecting fetch, decode, execute, retire and registers
`timescale 1ns/1ps
module rv_core #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall_i,
    input  logic [rv_core_pkg::XLEN-1:0] instruction_i,
    input  logic [rv_core_pkg::XLEN-1:0] mem_data_i,
    output logic [rv_core_pkg::XLEN-1:0] instruction_address_o,
    output logic                         mem_operation_enable_o,
    output logic [3:0]                   mem_write_enable_o,
    output logic [rv_core_pkg::XLEN-1:0] mem_address_o,
    output logic [rv_core_pkg::XLEN-1:0] mem_data_o
);
    import rv_core_pkg::*;

    localparam int TAG_WIDTH = DEFAULT_TAG_WIDTH;

    logic                  hazard;
    logic                  jump;
    logic [XLEN-1:0]       jump_target;
    logic [TAG_WIDTH-1:0]  retire_tag;
    logic [XLEN-1:0]       pc_fetch;
    logic [TAG_WIDTH-1:0]  tag_fetch;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  wb_enable;
    logic [XLEN-1:0]       wb_data;
    dec_ex_t               dec_bundle;
    ex_rt_t                ex_bundle;

    fetch_unit #(
        .RESET_PC (RESET_PC),
        .TAG_WIDTH(TAG_WIDTH)
    ) u_fetch (
        .clk                  (clk),
        .reset                (reset),
        .stall_i              (stall_i),
        .hazard_i             (hazard),
        .jump_i               (jump),
        .jump_target_i        (jump_target),
        .retire_tag_i         (retire_tag),
        .instruction_address_o(instruction_address_o),
        .pc_o                 (pc_fetch),
        .tag_o                (tag_fetch)
    );

    decode_stage #(
        .TAG_WIDTH(TAG_WIDTH)
    ) u_decode (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .instruction_i(instruction_i),
        .pc_i         (pc_fetch),
        .tag_i        (tag_fetch),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .hazard_o     (hazard),
        .dec_o        (dec_bundle)
    );

    register_file u_regs (
        .clk           (clk),
        .reset         (reset),
        .rs1_i         (rs1),
        .rs2_i         (rs2),
        .rd_i          (wb_rd),
        .write_enable_i(wb_enable),
        .data_i        (wb_data),
        .data1_o       (rs1_data),
        .data2_o       (rs2_data)
    );

    execute_stage #(
        .TAG_WIDTH(TAG_WIDTH)
    ) u_execute (
        .clk    (clk),
        .reset  (reset),
        .stall_i(stall_i),
        .dec_i  (dec_bundle),
        .ex_o   (ex_bundle)
    );

    retire_stage #(
        .TAG_WIDTH(TAG_WIDTH)
    ) u_retire (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .ex_i                  (ex_bundle),
        .mem_data_i            (mem_data_i),
        .rd_o                  (wb_rd),
        .write_enable_o        (wb_enable),
        .write_data_o          (wb_data),
        .jump_o                (jump),
        .jump_target_o         (jump_target),
        .retire_tag_o          (retire_tag),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o    (mem_write_enable_o),
        .mem_address_o         (mem_address_o),
        .mem_data_o            (mem_data_o)
    );

endmodule

// ==== source/retire_stage.sv ====
// retire stage with kill check, retire tag, jump redirect, load/store and writeback
`timescale 1ns/1ps
module retire_stage #(
    parameter int TAG_WIDTH = rv_core_pkg::DEFAULT_TAG_WIDTH
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stall_i,
    input  rv_core_pkg::ex_rt_t                ex_i,
    input  logic [rv_core_pkg::XLEN-1:0]       mem_data_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                               write_enable_o,
    output logic [rv_core_pkg::XLEN-1:0]       write_data_o,
    output logic                               jump_o,
    output logic [rv_core_pkg::XLEN-1:0]       jump_target_o,
    output logic [TAG_WIDTH-1:0]               retire_tag_o,
    output logic                               mem_operation_enable_o,
    output logic [3:0]                         mem_write_enable_o,
    output logic [rv_core_pkg::XLEN-1:0]       mem_address_o,
    output logic [rv_core_pkg::XLEN-1:0]       mem_data_o
);
    import rv_core_pkg::*;

    logic [TAG_WIDTH-1:0] tag_q;
    logic                 killed;
    logic                 active;
    logic                 is_load;
    logic                 is_store;

    // items fetched before the last jump carry an old tag
    assign killed   = ex_i.tag != tag_q;
    assign active   = ex_i.valid && !killed && !stall_i;
    assign is_load  = ex_i.operation == LW;
    assign is_store = ex_i.operation == SW;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_q <= '0;
        end else if (jump_o) begin
            tag_q <= tag_q + 1'b1;
        end
    end

    assign retire_tag_o  = tag_q;
    assign jump_o        = active && ex_i.jump;
    assign jump_target_o = ex_i.jump_target;

    assign rd_o           = ex_i.rd;
    assign write_enable_o = active && ex_i.write_enable;
    assign write_data_o   = is_load ? mem_data_i : ex_i.result;

    // word access only, all byte lanes on a store
    assign mem_operation_enable_o = active && (is_load || is_store);
    assign mem_write_enable_o     = (active && is_store) ? 4'b1111 : 4'b0000;
    assign mem_address_o          = {ex_i.result[XLEN-1:2], 2'b00};
    assign mem_data_o             = ex_i.store_data;

endmodule

// ==== source/execute_stage.sv ====
// execute stage with ALU, shifter, branch compare, jump target and address adder
`timescale 1ns/1ps
module execute_stage #(
    parameter int TAG_WIDTH = rv_core_pkg::DEFAULT_TAG_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall_i,
    input  rv_core_pkg::dec_ex_t dec_i,
    output rv_core_pkg::ex_rt_t  ex_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0]      sum;
    logic [XLEN-1:0]      link;
    logic [4:0]           shamt;
    logic [TAG_WIDTH-1:0] tag;
    logic                 taken;
    ex_rt_t               ex_d;
    ex_rt_t               ex_q;

    // shared adder for ADD, AUIPC, JAL, JALR and memory addresses
    assign sum   = dec_i.first + dec_i.second;
    assign link  = dec_i.pc + XLEN'(4);
    assign shamt = dec_i.second[4:0];
    assign tag   = dec_i.tag;

    always_comb begin
        case (dec_i.operation)
            BEQ:     taken = dec_i.first == dec_i.second;
            BNE:     taken = dec_i.first != dec_i.second;
            BLT:     taken = $signed(dec_i.first) < $signed(dec_i.second);
            BGE:     taken = $signed(dec_i.first) >= $signed(dec_i.second);
            BLTU:    taken = dec_i.first < dec_i.second;
            BGEU:    taken = dec_i.first >= dec_i.second;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ex_d              = '0;
        ex_d.valid        = dec_i.valid;
        ex_d.operation    = dec_i.operation;
        ex_d.store_data   = dec_i.third;
        ex_d.rd           = dec_i.rd;
        ex_d.tag          = tag;
        ex_d.result       = sum;
        ex_d.jump         = taken;
        ex_d.jump_target  = dec_i.pc + dec_i.third;
        ex_d.write_enable = 1'b1;
        case (dec_i.operation)
            LUI:  ex_d.result = dec_i.second;
            SUB:  ex_d.result = dec_i.first - dec_i.second;
            SLT:  ex_d.result = {{(XLEN-1){1'b0}}, $signed(dec_i.first) < $signed(dec_i.second)};
            SLTU: ex_d.result = {{(XLEN-1){1'b0}}, dec_i.first < dec_i.second};
            XOR:  ex_d.result = dec_i.first ^ dec_i.second;
            OR:   ex_d.result = dec_i.first | dec_i.second;
            AND:  ex_d.result = dec_i.first & dec_i.second;
            SLL:  ex_d.result = dec_i.first << shamt;
            SRL:  ex_d.result = dec_i.first >> shamt;
            SRA:  ex_d.result = $signed(dec_i.first) >>> shamt;
            JAL, JALR: begin
                ex_d.result      = link;
                ex_d.jump        = 1'b1;
                ex_d.jump_target = {sum[XLEN-1:1], 1'b0};
            end
            NOP, SW, BEQ, BNE, BLT, BGE, BLTU, BGEU: ex_d.write_enable = 1'b0;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_q.valid <= 1'b0;
        end else if (!stall_i) begin
            ex_q <= ex_d;
        end
    end

    assign ex_o = ex_q;

endmodule

// ==== source/register_file.sv ====
// register bank with hardwired x0 and write-through read bypass
`timescale 1ns/1ps
module register_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                               write_enable_i,
    input  logic [rv_core_pkg::XLEN-1:0]       data_i,
    output logic [rv_core_pkg::XLEN-1:0]       data1_o,
    output logic [rv_core_pkg::XLEN-1:0]       data2_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [1:31];
    logic            write_valid;

    function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        // same-cycle writeback is forwarded
        if (write_valid && addr == rd_i) begin
            return data_i;
        end
        return regs[addr];
    endfunction

    assign write_valid = write_enable_i && rd_i != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_valid) begin
            regs[rd_i] <= data_i;
        end
    end

    always_comb begin
        data1_o = read_reg(rs1_i);
        data2_o = read_reg(rs2_i);
    end

endmodule

// ==== source/decode_stage.sv ====
// decode stage with operation decode, immediates, operand select and hazard check
`timescale 1ns/1ps
module decode_stage #(
    parameter int TAG_WIDTH = rv_core_pkg::DEFAULT_TAG_WIDTH
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stall_i,
    input  rv_core_pkg::instr_u                instruction_i,
    input  logic [rv_core_pkg::XLEN-1:0]       pc_i,
    input  logic [TAG_WIDTH-1:0]               tag_i,
    input  logic [rv_core_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0]       rs2_data_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic                               hazard_o,
    output rv_core_pkg::dec_ex_t               dec_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] word;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [2:0]      funct3;
    logic            alt;
    dec_ex_t         dec_d;
    dec_ex_t         dec_q;

    // alt selects SUB over ADD and SRA over SRL
    function automatic operation_e alu_op(input logic [2:0] f3, input logic sel);
        case (f3)
            3'b000:  return sel ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return sel ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign word   = instruction_i;
    assign funct3 = instruction_i.r_fmt.funct3;
    assign alt    = instruction_i.r_fmt.funct7[5];
    assign rs1_o  = instruction_i.r_fmt.rs1;
    assign rs2_o  = instruction_i.r_fmt.rs2;

    assign imm_i = {{20{word[31]}}, instruction_i.r_fmt.funct7, instruction_i.r_fmt.rs2};
    assign imm_s = {{20{word[31]}}, instruction_i.s_fmt.imm_hi, instruction_i.s_fmt.imm_lo};
    assign imm_b = {{20{word[31]}}, instruction_i.s_fmt.imm_lo[0],
                    instruction_i.s_fmt.imm_hi[5:0], instruction_i.s_fmt.imm_lo[4:1], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

    always_comb begin
        dec_d           = '0;
        dec_d.valid     = !hazard_o;
        dec_d.pc        = pc_i;
        dec_d.first     = rs1_data_i;
        dec_d.second    = imm_i;
        dec_d.third     = rs2_data_i;
        dec_d.rd        = instruction_i.r_fmt.rd;
        dec_d.tag       = tag_i;
        case (instruction_i.r_fmt.opcode)
            OPC_LUI: begin
                dec_d.operation = LUI;
                dec_d.second    = imm_u;
            end
            OPC_AUIPC: begin
                dec_d.operation = ADD;
                dec_d.first     = pc_i;
                dec_d.second    = imm_u;
            end
            OPC_OP_IMM: dec_d.operation = alu_op(funct3, alt && funct3 == 3'b101);
            OPC_OP: begin
                dec_d.operation = alu_op(funct3, alt);
                dec_d.second    = rs2_data_i;
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  dec_d.operation = BEQ;
                    3'b001:  dec_d.operation = BNE;
                    3'b100:  dec_d.operation = BLT;
                    3'b101:  dec_d.operation = BGE;
                    3'b110:  dec_d.operation = BLTU;
                    3'b111:  dec_d.operation = BGEU;
                    default: dec_d.operation = NOP;
                endcase
                dec_d.second = rs2_data_i;
                dec_d.third  = imm_b;
            end
            OPC_JAL: begin
                dec_d.operation = JAL;
                dec_d.first     = pc_i;
                dec_d.second    = imm_j;
            end
            OPC_JALR: dec_d.operation = JALR;
            OPC_LOAD: dec_d.operation = (funct3 == 3'b010) ? LW : NOP;
            OPC_STORE: begin
                dec_d.operation = (funct3 == 3'b010) ? SW : NOP;
                dec_d.second    = imm_s;
            end
            default: dec_d.operation = NOP;
        endcase
        // only register writers keep a destination
        if (dec_d.operation inside {NOP, SW, BEQ, BNE, BLT, BGE, BLTU, BGEU}) begin
            dec_d.rd = '0;
        end
    end

    // result of the item in execute is not yet in the register file
    assign hazard_o = dec_q.valid && dec_q.rd != '0 &&
                      (dec_q.rd == rs1_o || dec_q.rd == rs2_o);

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_q.valid <= 1'b0;
        end else if (!stall_i) begin
            dec_q <= dec_d;
        end
    end

    assign dec_o = dec_q;

endmodule

// ==== source/fetch_unit.sv ====
// fetch unit with program counter, jump redirect and instruction tag
`timescale 1ns/1ps
module fetch_unit #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC  = '0,
    parameter int                           TAG_WIDTH = rv_core_pkg::DEFAULT_TAG_WIDTH
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall_i,
    input  logic                         hazard_i,
    input  logic                         jump_i,
    input  logic [rv_core_pkg::XLEN-1:0] jump_target_i,
    input  logic [TAG_WIDTH-1:0]         retire_tag_i,
    output logic [rv_core_pkg::XLEN-1:0] instruction_address_o,
    output logic [rv_core_pkg::XLEN-1:0] pc_o,
    output logic [TAG_WIDTH-1:0]         tag_o
);
    import rv_core_pkg::*;

    logic [XLEN-1:0]      pc_q;
    logic [TAG_WIDTH-1:0] tag_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q  <= RESET_PC;
            tag_q <= '0;
        end else if (!stall_i) begin
            // jump wins over a hazard, the held instruction is on the wrong path
            if (jump_i) begin
                pc_q  <= jump_target_i;
                tag_q <= retire_tag_i + 1'b1;
            end else if (!hazard_i) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    // memory answers in the same cycle, so pc and tag line up with instruction_i
    assign instruction_address_o = pc_q;
    assign pc_o                  = pc_q;
    assign tag_o                 = tag_q;

endmodule

// ==== source/rv_core_pkg.sv ====
// widths, opcodes, operation codes, instruction formats and pipeline bundles of the core
package rv_core_pkg;

    localparam int XLEN              = 32;
    localparam int REG_ADDR_W        = 5;
    localparam int DEFAULT_TAG_WIDTH = 3;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    // NOP must stay at zero, it is the value of an empty bundle
    typedef enum logic [4:0] {
        NOP, LUI,
        ADD, SUB, SLT, SLTU,
        XOR, OR, AND,
        SLL, SRL, SRA,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR,
        LW, SW
    } operation_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        opcode_e               opcode;
    } s_fmt_t;

    // one instruction word, seen as register format or as store format
    typedef union packed {
        r_fmt_t r_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    typedef struct packed {
        logic                         valid;
        operation_e                   operation;
        logic [XLEN-1:0]              pc;
        logic [XLEN-1:0]              first;
        logic [XLEN-1:0]              second;
        logic [XLEN-1:0]              third;
        logic [REG_ADDR_W-1:0]        rd;
        logic [DEFAULT_TAG_WIDTH-1:0] tag;
    } dec_ex_t;

    typedef struct packed {
        logic                         valid;
        operation_e                   operation;
        logic [XLEN-1:0]              result;
        logic [XLEN-1:0]              store_data;
        logic                         jump;
        logic [XLEN-1:0]              jump_target;
        logic [REG_ADDR_W-1:0]        rd;
        logic                         write_enable;
        logic [DEFAULT_TAG_WIDTH-1:0] tag;
    } ex_rt_t;

endpackage
